//--- rv_backend.f
rv_pkg.sv
stall_ctrl.sv
ex_mem.sv
mem_access.sv
mem_wb.sv
regfile.sv
commit_monitor.sv
rv_backend.sv
rv_backend_asserts.sv
rv_backend_tb.sv

//--- Makefile
TOP := rv_backend_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rv_backend.f -o $(TOP)

# Error limit raised so every assertion failure is counted instead of stopping the run
run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rv_backend_tb.sv
// Testbench for the RV64 back end, drives issue and data memory, checks retire and registers
`timescale 1ns/10ps

module rv_backend_tb import rv_pkg::*; ();

    localparam int N_ALU      = 12;
    localparam int N_MEM      = 8;
    localparam int DMEM_WORDS = 64;
    // x0 write, ALU burst, stores and loads, then store/load/ebreak
    localparam int TOTAL_OPS       = 1 + N_ALU + 2 * N_MEM + 3;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_OPS + 400;
    localparam int DRAIN_CYCLES    = 100;

    logic                  clk = 1'b0;
    logic                  arst_n_i;
    logic                  ex_valid_i;
    op_e                   ex_op_i;
    logic [XLEN-1:0]       ex_pc_i;
    logic [INST_W-1:0]     ex_inst_i;
    logic [REG_ADDR_W-1:0] ex_rd_addr_i;
    logic [XLEN-1:0]       ex_result_i;
    logic [XLEN-1:0]       ex_store_data_i;
    logic                  dmem_ack_i;
    logic [XLEN-1:0]       dmem_rdata_i;
    logic [REG_ADDR_W-1:0] rf_raddr_i;
    logic                  ex_ready_o;
    logic                  dmem_req_o;
    logic                  dmem_we_o;
    logic [XLEN-1:0]       dmem_addr_o;
    logic [XLEN-1:0]       dmem_wdata_o;
    logic [XLEN-1:0]       rf_rdata_o;
    logic                  retire_o;
    logic [XLEN-1:0]       retire_pc_o;
    logic [INST_W-1:0]     retire_inst_o;
    logic                  trap_o;
    logic [XLEN-1:0]       trap_code_o;
    logic                  halted_o;

    logic [XLEN-1:0]   exp_regs [NUM_REGS];
    logic [XLEN-1:0]   exp_mem [DMEM_WORDS];
    logic [XLEN-1:0]   dmem [DMEM_WORDS];  // Responder storage
    logic [XLEN-1:0]   exp_pc_q [$];
    logic [INST_W-1:0] exp_inst_q [$];
    logic [2*XLEN:0]   exp_req_q [$];  // We, address and write data per access
    logic [XLEN-1:0]   next_pc;
    int                mem_idx [N_MEM];
    int                issued;
    int                mismatch_count;
    int                other_count;
    int                retired = 0;
    int                retire_mismatch = 0;
    int                retire_other = 0;

    always #2 clk = ~clk;

    rv_backend rv_backend_inst (.*);

    function automatic logic [XLEN-1:0] fill_word(input int idx);
        return {32'(idx) ^ 32'h5A5A_0000, 32'(idx) * 32'h0101_0101};
    endfunction

    function automatic logic [XLEN-1:0] word_addr(input int idx);
        return {55'd0, 6'(idx), 3'b000};
    endfunction

    function automatic logic [INST_W-1:0] encode_inst(input op_e op,
                                                      input logic [REG_ADDR_W-1:0] rd);
        case (op)
            OP_ALU:    return {20'd0, rd, 7'h33};
            OP_LOAD:   return {17'd0, 3'b011, rd, 7'h03};  // ld
            OP_STORE:  return {25'd0, 7'h23};
            OP_EBREAK: return EBREAK_INST;
            default:   return 32'h0000_0013;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got == exp) else begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Called just after a rising edge, returns just after the accepting edge
    task automatic issue_op(input op_e op, input logic [REG_ADDR_W-1:0] rd,
                            input logic [XLEN-1:0] result, input logic [XLEN-1:0] sdata);
        logic [INST_W-1:0] inst;
        inst = encode_inst(op, rd);
        ex_valid_i      <= 1'b1;
        ex_op_i         <= op;
        ex_pc_i         <= next_pc;
        ex_inst_i       <= inst;
        ex_rd_addr_i    <= rd;
        ex_result_i     <= result;
        ex_store_data_i <= sdata;
        @(negedge clk);
        while (!ex_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        case (op)
            OP_ALU:   if (rd != '0) exp_regs[rd] = result;
            OP_LOAD: begin
                if (rd != '0) exp_regs[rd] = exp_mem[result[8:3]];
                exp_req_q.push_back({1'b0, result, sdata});
            end
            OP_STORE: begin
                exp_mem[result[8:3]] = sdata;
                exp_req_q.push_back({1'b1, result, sdata});
            end
            default:  ;
        endcase
        exp_pc_q.push_back(next_pc);
        exp_inst_q.push_back(inst);
        next_pc = next_pc + 64'd4;
        issued++;
    endtask

    // Waits until every accepted operation has retired, returns just after a rising edge
    task automatic drain();
        int cycles;
        cycles = 0;
        ex_valid_i <= 1'b0;
        while (retired < issued && cycles < DRAIN_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (retired != issued) begin
            other_count++;
            $display("accepted %0d operations but %0d retired", issued, retired);
        end
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            rf_raddr_i <= 5'(i);
            @(negedge clk);
            check_value($sformatf("rf_rdata_o[x%0d]", i), rf_rdata_o, exp_regs[i]);
            @(posedge clk);
        end
    endtask

    // Retire order and count against the accepted operations
    always @(negedge clk) begin
        if (arst_n_i && retire_o) begin
            if (retired >= exp_pc_q.size()) begin
                retire_other++;
                $display("retire seen with no accepted operation outstanding, pc %h",
                         retire_pc_o);
            end else begin
                assert (retire_pc_o == exp_pc_q[retired]) else begin
                    retire_mismatch++;
                    $display("mismatch retire_pc_o: got %h expected %h",
                             retire_pc_o, exp_pc_q[retired]);
                end
                assert (retire_inst_o == exp_inst_q[retired]) else begin
                    retire_mismatch++;
                    $display("mismatch retire_inst_o: got %h expected %h",
                             retire_inst_o, exp_inst_q[retired]);
                end
                retired++;
            end
        end
    end

    // Four-phase data memory responder with random ack delay
    initial begin
        int          delay;
        int          idx;
        logic        we;
        logic [XLEN-1:0] wdata;
        logic [2*XLEN:0] exp_req;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(i);
        end
        dmem_ack_i   <= 1'b0;
        dmem_rdata_i <= '0;
        forever begin
            @(negedge clk);
            if (arst_n_i && dmem_req_o) begin
                idx   = int'(dmem_addr_o[8:3]);
                we    = dmem_we_o;
                wdata = dmem_wdata_o;
                if (exp_req_q.size() == 0) begin
                    other_count++;
                    $display("data memory request with no load or store accepted, address %h",
                             dmem_addr_o);
                end else begin
                    exp_req = exp_req_q.pop_front();
                    check_value("dmem_we_o", 64'(we), 64'(exp_req[2*XLEN]));
                    check_value("dmem_addr_o", dmem_addr_o, exp_req[2*XLEN-1:XLEN]);
                    if (exp_req[2*XLEN]) begin
                        check_value("dmem_wdata_o", wdata, exp_req[XLEN-1:0]);
                    end
                end
                delay = $urandom_range(5, 0);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                if (we) begin
                    dmem[idx] = wdata;
                end
                dmem_ack_i   <= 1'b1;
                dmem_rdata_i <= we ? '0 : dmem[idx];
                do begin
                    @(negedge clk);
                end while (dmem_req_o);
                @(posedge clk);
                dmem_ack_i   <= 1'b0;
                dmem_rdata_i <= '0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int a0_idx;
        int total;
        int assert_fails;
        void'($urandom(56));
        arst_n_i        <= 1'b0;
        ex_valid_i      <= 1'b0;
        ex_op_i         <= OP_NONE;
        ex_pc_i         <= '0;
        ex_inst_i       <= '0;
        ex_rd_addr_i    <= '0;
        ex_result_i     <= '0;
        ex_store_data_i <= '0;
        rf_raddr_i      <= '0;
        next_pc        = 64'h0000_0000_8000_0000;
        issued         = 0;
        mismatch_count = 0;
        other_count    = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            exp_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            exp_mem[i] = fill_word(i);
        end
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;

        // Reset state
        @(negedge clk);
        check_value("ex_ready_o", 64'(ex_ready_o), 64'd1);
        check_value("dmem_req_o", 64'(dmem_req_o), 64'd0);
        check_value("retire_o", 64'(retire_o), 64'd0);
        check_value("trap_o", 64'(trap_o), 64'd0);
        check_value("halted_o", 64'(halted_o), 64'd0);
        @(posedge clk);
        check_all_regs();

        // Back-to-back ALU, first one aimed at x0
        issue_op(OP_ALU, 5'd0, 64'hDEAD_BEEF_0BAD_F00D, '0);
        for (int n = 0; n < N_ALU; n++) begin
            issue_op(OP_ALU, 5'($urandom_range(31, 1)), {$urandom, $urandom}, '0);
        end
        drain();
        check_all_regs();

        // Stores then loads from the same words
        for (int n = 0; n < N_MEM; n++) begin
            mem_idx[n] = $urandom_range(DMEM_WORDS - 1, 0);
            issue_op(OP_STORE, 5'd0, word_addr(mem_idx[n]), {$urandom, $urandom});
        end
        for (int n = 0; n < N_MEM; n++) begin
            issue_op(OP_LOAD, 5'($urandom_range(31, 1)), word_addr(mem_idx[n]), '0);
        end
        drain();
        check_all_regs();

        // Load a random exit code into a0, then ebreak
        a0_idx = $urandom_range(DMEM_WORDS - 1, 0);
        issue_op(OP_STORE, 5'd0, word_addr(a0_idx), {$urandom, $urandom});
        issue_op(OP_LOAD, A0_IDX, word_addr(a0_idx), '0);
        issue_op(OP_EBREAK, 5'd0, '0, '0);
        ex_valid_i <= 1'b0;
        while (!trap_o) begin
            @(negedge clk);
        end
        check_value("retire_o", 64'(retire_o), 64'd1);  // Trap comes with the ebreak retire
        check_value("halted_o", 64'(halted_o), 64'd1);
        check_value("trap_code_o", trap_code_o, exp_regs[A0_IDX]);
        @(posedge clk);

        // Offer one more op, the halted pipe must not take it
        ex_valid_i   <= 1'b1;
        ex_op_i      <= OP_ALU;
        ex_pc_i      <= next_pc;
        ex_inst_i    <= encode_inst(OP_ALU, 5'd1);
        ex_rd_addr_i <= 5'd1;
        ex_result_i  <= 64'h1111_2222_3333_4444;
        repeat (10) @(posedge clk);
        drain();
        check_all_regs();

        assert_fails = rv_backend_inst.rv_backend_asserts_inst.fail_count;
        total = mismatch_count + retire_mismatch + other_count + retire_other + assert_fails;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count + retire_mismatch, other_count + retire_other, assert_fails);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rv_backend_asserts.sv
// Bound checks on the data-memory handshake, issue stall and halt behavior
`timescale 1ns/10ps

module rv_backend_asserts import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            req_i,
    input  logic            ack_i,
    input  logic            we_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic            ready_i,
    input  logic            retire_i,
    input  logic            halted_i,
    input  logic [XLEN-1:0] trap_code_i
);

    int fail_count = 0;

    req_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_i && !ack_i |=> req_i)
        else begin
            $error("dmem_req_o dropped before dmem_ack_i was seen");
            fail_count++;
        end

    no_req_during_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(req_i) |-> !ack_i)
        else begin
            $error("new dmem_req_o raised while dmem_ack_i still high");
            fail_count++;
        end

    // Address, data and direction frozen for the whole request
    req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_i |=> !req_i || ($stable(addr_i) && $stable(wdata_i) && $stable(we_i)))
        else begin
            $error("dmem address, write data or write enable changed while req high");
            fail_count++;
        end

    busy_blocks_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
        (req_i || ack_i) |-> !ready_i)
        else begin
            $error("ex_ready_o high while a data memory access is outstanding");
            fail_count++;
        end

    halt_blocks_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
        halted_i |-> !ready_i)
        else begin
            $error("ex_ready_o high after halt");
            fail_count++;
        end

    no_retire_after_halt: assert property (@(posedge clk) disable iff (!arst_n_i)
        halted_i |=> !retire_i)
        else begin
            $error("retire_o pulsed after the trap");
            fail_count++;
        end

    trap_code_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        halted_i |=> $stable(trap_code_i))
        else begin
            $error("trap_code_o changed after the trap");
            fail_count++;
        end

endmodule

bind rv_backend rv_backend_asserts rv_backend_asserts_inst (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_i       (dmem_req_o),
    .ack_i       (dmem_ack_i),
    .we_i        (dmem_we_o),
    .addr_i      (dmem_addr_o),
    .wdata_i     (dmem_wdata_o),
    .ready_i     (ex_ready_o),
    .retire_i    (retire_o),
    .halted_i    (halted_o),
    .trap_code_i (trap_code_o)
);

//--- rv_backend.sv
// Back end top level, connects the execute/memory/writeback stages
`timescale 1ns/10ps

module rv_backend import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  ex_valid_i,
    input  op_e                   ex_op_i,
    input  logic [XLEN-1:0]       ex_pc_i,
    input  logic [INST_W-1:0]     ex_inst_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
    input  logic [XLEN-1:0]       ex_result_i,
    input  logic [XLEN-1:0]       ex_store_data_i,
    input  logic                  dmem_ack_i,
    input  logic [XLEN-1:0]       dmem_rdata_i,
    input  logic [REG_ADDR_W-1:0] rf_raddr_i,
    output logic                  ex_ready_o,
    output logic                  dmem_req_o,
    output logic                  dmem_we_o,
    output logic [XLEN-1:0]       dmem_addr_o,
    output logic [XLEN-1:0]       dmem_wdata_o,
    output logic [XLEN-1:0]       rf_rdata_o,
    output logic                  retire_o,
    output logic [XLEN-1:0]       retire_pc_o,
    output logic [INST_W-1:0]     retire_inst_o,
    output logic                  trap_o,
    output logic [XLEN-1:0]       trap_code_o,
    output logic                  halted_o
);

    logic [STALL_W-1:0]    stall;
    op_e                   xm_op;
    logic [XLEN-1:0]       xm_pc;
    logic [INST_W-1:0]     xm_inst;
    logic [REG_ADDR_W-1:0] xm_rd_addr;
    logic [XLEN-1:0]       xm_result;
    logic [XLEN-1:0]       xm_store_data;
    logic                  mem_busy;
    logic                  mem_rd_ena;
    logic [REG_ADDR_W-1:0] mem_rd_addr;
    logic [XLEN-1:0]       mem_rd_data;
    logic [XLEN-1:0]       mem_pc;
    logic [INST_W-1:0]     mem_inst;
    logic                  wb_rd_ena;
    logic [REG_ADDR_W-1:0] wb_rd_addr;
    logic [XLEN-1:0]       wb_rd_data;
    logic [XLEN-1:0]       wb_pc;
    logic [INST_W-1:0]     wb_inst;
    logic [XLEN-1:0]       a0;

    assign ex_ready_o = !stall[STALL_ISSUE];

    stall_ctrl stall_ctrl_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .mem_busy_i (mem_busy),
        .halted_i   (halted_o),
        .stall_o    (stall)
    );

    ex_mem ex_mem_inst (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall),
        .ex_valid_i      (ex_valid_i),
        .ex_op_i         (ex_op_i),
        .ex_pc_i         (ex_pc_i),
        .ex_inst_i       (ex_inst_i),
        .ex_rd_addr_i    (ex_rd_addr_i),
        .ex_result_i     (ex_result_i),
        .ex_store_data_i (ex_store_data_i),
        .op_o            (xm_op),
        .pc_o            (xm_pc),
        .inst_o          (xm_inst),
        .rd_addr_o       (xm_rd_addr),
        .result_o        (xm_result),
        .store_data_o    (xm_store_data)
    );

    mem_access mem_access_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .op_i         (xm_op),
        .pc_i         (xm_pc),
        .inst_i       (xm_inst),
        .rd_addr_i    (xm_rd_addr),
        .result_i     (xm_result),
        .store_data_i (xm_store_data),
        .dmem_ack_i   (dmem_ack_i),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .busy_o       (mem_busy),
        .rd_ena_o     (mem_rd_ena),
        .rd_addr_o    (mem_rd_addr),
        .rd_data_o    (mem_rd_data),
        .pc_o         (mem_pc),
        .inst_o       (mem_inst)
    );

    mem_wb mem_wb_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall),
        .mem_rd_ena_i  (mem_rd_ena),
        .mem_rd_addr_i (mem_rd_addr),
        .mem_rd_data_i (mem_rd_data),
        .mem_pc_i      (mem_pc),
        .mem_inst_i    (mem_inst),
        .wb_rd_ena_o   (wb_rd_ena),
        .wb_rd_addr_o  (wb_rd_addr),
        .wb_rd_data_o  (wb_rd_data),
        .wb_pc_o       (wb_pc),
        .wb_inst_o     (wb_inst)
    );

    regfile regfile_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_rd_ena),
        .waddr_i  (wb_rd_addr),
        .wdata_i  (wb_rd_data),
        .raddr_i  (rf_raddr_i),
        .rdata_o  (rf_rdata_o),
        .a0_o     (a0)
    );

    commit_monitor commit_monitor_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .wb_pc_i       (wb_pc),
        .wb_inst_i     (wb_inst),
        .a0_i          (a0),
        .retire_o      (retire_o),
        .retire_pc_o   (retire_pc_o),
        .retire_inst_o (retire_inst_o),
        .trap_o        (trap_o),
        .trap_code_o   (trap_code_o),
        .halted_o      (halted_o)
    );

endmodule

//--- commit_monitor.sv
// Commit monitor, reports retired instructions and detects the ebreak trap
`timescale 1ns/10ps

module commit_monitor import rv_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic [XLEN-1:0]   wb_pc_i,
    input  logic [INST_W-1:0] wb_inst_i,
    input  logic [XLEN-1:0]   a0_i,
    output logic              retire_o,
    output logic [XLEN-1:0]   retire_pc_o,
    output logic [INST_W-1:0] retire_inst_o,
    output logic              trap_o,
    output logic [XLEN-1:0]   trap_code_o,
    output logic              halted_o
);

    logic is_inst;
    logic is_ebreak;

    assign is_inst   = (wb_inst_i != '0);
    assign is_ebreak = (wb_inst_i == EBREAK_INST);

    // Retire one cycle after writeback, frozen wb contents never repeat
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_o      <= 1'b0;
            retire_pc_o   <= '0;
            retire_inst_o <= '0;
        end else begin
            retire_o <= is_inst && !halted_o;
            if (!halted_o) begin
                retire_pc_o   <= wb_pc_i;
                retire_inst_o <= wb_inst_i;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trap_o      <= 1'b0;
            halted_o    <= 1'b0;
            trap_code_o <= '0;
        end else if (is_ebreak && !halted_o) begin
            trap_o      <= 1'b1;  // Sticky until reset
            halted_o    <= 1'b1;
            trap_code_o <= a0_i;
        end
    end

endmodule

//--- regfile.sv
// Register file, 32 x 64 with x0 hardwired to zero and an a0 tap
`timescale 1ns/10ps

module regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr_i,
    output logic [XLEN-1:0]       rdata_o,
    output logic [XLEN-1:0]       a0_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // No bypass, same-cycle read sees the old value
    assign rdata_o = regs[raddr_i];
    assign a0_o    = regs[A0_IDX];  // Exit code for the trap

endmodule

//--- mem_wb.sv
// Memory/writeback pipeline register, carries pc and instruction on to commit
`timescale 1ns/10ps

module mem_wb import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [STALL_W-1:0]    stall_i,
    input  logic                  mem_rd_ena_i,
    input  logic [REG_ADDR_W-1:0] mem_rd_addr_i,
    input  logic [XLEN-1:0]       mem_rd_data_i,
    input  logic [XLEN-1:0]       mem_pc_i,
    input  logic [INST_W-1:0]     mem_inst_i,
    output logic                  wb_rd_ena_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic [XLEN-1:0]       wb_rd_data_o,
    output logic [XLEN-1:0]       wb_pc_o,
    output logic [INST_W-1:0]     wb_inst_o
);

    // A zero instruction marks a bubble. The memory stage already zeroes
    // its outputs while busy, so no separate bubble case is needed here
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_rd_ena_o  <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= '0;
            wb_pc_o      <= '0;
            wb_inst_o    <= '0;
        end else if (!stall_i[STALL_WB]) begin
            wb_rd_ena_o  <= mem_rd_ena_i;
            wb_rd_addr_o <= mem_rd_addr_i;
            wb_rd_data_o <= mem_rd_data_i;
            wb_pc_o      <= mem_pc_i;
            wb_inst_o    <= mem_inst_i;
        end
    end

endmodule

//--- mem_access.sv
// Memory stage, runs the four-phase req/ack handshake for loads and stores
`timescale 1ns/10ps

module mem_access import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  op_e                   op_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [INST_W-1:0]     inst_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic [XLEN-1:0]       result_i,
    input  logic [XLEN-1:0]       store_data_i,
    input  logic                  dmem_ack_i,
    input  logic [XLEN-1:0]       dmem_rdata_i,
    output logic                  dmem_req_o,
    output logic                  dmem_we_o,
    output logic [XLEN-1:0]       dmem_addr_o,
    output logic [XLEN-1:0]       dmem_wdata_o,
    output logic                  busy_o,
    output logic                  rd_ena_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       rd_data_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [INST_W-1:0]     inst_o
);

    mem_state_e      state;
    logic [XLEN-1:0] rdata_q;
    logic            is_mem;
    logic            present;
    logic            writes_rd;

    assign is_mem = (op_i == OP_LOAD) || (op_i == OP_STORE);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= MEM_IDLE;
        end else begin
            case (state)
                MEM_IDLE:    if (is_mem) state <= MEM_REQ;
                MEM_REQ:     if (dmem_ack_i) state <= MEM_RELEASE;
                MEM_RELEASE: if (!dmem_ack_i) state <= MEM_DONE;
                default:     state <= MEM_IDLE;  // MEM_DONE, op leaves this cycle
            endcase
        end
    end

    // Read data is valid only while ack is high
    always_ff @(posedge clk) begin
        if (state == MEM_REQ && dmem_ack_i) begin
            rdata_q <= dmem_rdata_i;
        end
    end

    assign dmem_req_o   = (state == MEM_REQ);
    assign dmem_we_o    = dmem_req_o && (op_i == OP_STORE);
    assign dmem_addr_o  = result_i;      // ex_mem holds these under stall
    assign dmem_wdata_o = store_data_i;
    assign busy_o       = is_mem && (state != MEM_DONE);

    always_comb begin
        case (op_i)
            OP_ALU, OP_EBREAK: present = 1'b1;
            OP_LOAD, OP_STORE: present = (state == MEM_DONE);
            default:           present = 1'b0;
        endcase
        writes_rd = (op_i == OP_ALU) || (op_i == OP_LOAD);
    end

    always_comb begin
        rd_ena_o  = 1'b0;
        rd_addr_o = '0;
        rd_data_o = '0;
        pc_o      = '0;
        inst_o    = '0;
        if (present) begin
            rd_ena_o  = writes_rd && (rd_addr_i != '0);
            rd_addr_o = rd_addr_i;
            rd_data_o = (op_i == OP_LOAD) ? rdata_q : result_i;
            pc_o      = pc_i;
            inst_o    = inst_i;
        end
    end

endmodule

//--- ex_mem.sv
// Execute/memory pipeline register with hold and bubble insertion
`timescale 1ns/10ps

module ex_mem import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [STALL_W-1:0]    stall_i,
    input  logic                  ex_valid_i,
    input  op_e                   ex_op_i,
    input  logic [XLEN-1:0]       ex_pc_i,
    input  logic [INST_W-1:0]     ex_inst_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
    input  logic [XLEN-1:0]       ex_result_i,
    input  logic [XLEN-1:0]       ex_store_data_i,
    output op_e                   op_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [INST_W-1:0]     inst_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       result_o,
    output logic [XLEN-1:0]       store_data_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_o         <= OP_NONE;
            pc_o         <= '0;
            inst_o       <= '0;
            rd_addr_o    <= '0;
            result_o     <= '0;
            store_data_o <= '0;
        end else if (!stall_i[STALL_EXMEM]) begin
            if (ex_valid_i && !stall_i[STALL_ISSUE]) begin
                op_o         <= ex_op_i;
                pc_o         <= ex_pc_i;
                inst_o       <= ex_inst_i;
                rd_addr_o    <= ex_rd_addr_i;
                result_o     <= ex_result_i;
                store_data_o <= ex_store_data_i;
            end else begin
                // Nothing issued, also retires a finished memory op
                op_o         <= OP_NONE;
                pc_o         <= '0;
                inst_o       <= '0;
                rd_addr_o    <= '0;
                result_o     <= '0;
                store_data_o <= '0;
            end
        end
    end

endmodule

//--- stall_ctrl.sv
// Stall controller, builds the per-stage stall vector from memory busy and halt
`timescale 1ns/10ps

module stall_ctrl import rv_pkg::*; (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               mem_busy_i,
    input  logic               halted_i,
    output logic [STALL_W-1:0] stall_o
);

    logic halt_q;
    logic frozen;

    // Sticky copy of the halt, keeps the pipe frozen until reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            halt_q <= 1'b0;
        end else if (halted_i) begin
            halt_q <= 1'b1;
        end
    end

    assign frozen = halted_i | halt_q;

    always_comb begin
        stall_o = '0;
        if (frozen) begin
            stall_o[STALL_ISSUE] = 1'b1;
            stall_o[STALL_EXMEM] = 1'b1;
            stall_o[STALL_MEM]   = 1'b1;
            stall_o[STALL_WB]    = 1'b1;
        end else if (mem_busy_i) begin
            // Hold the front, mem_wb takes the bubble from mem_access
            stall_o[STALL_ISSUE] = 1'b1;
            stall_o[STALL_EXMEM] = 1'b1;
        end
    end

endmodule

//--- rv_pkg.sv
// Shared widths, stall vector layout and encodings for the RV64 back end
package rv_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Stall vector, one bit per stage
    localparam int STALL_W     = 4;
    localparam int STALL_ISSUE = 0;  // Upstream issue
    localparam int STALL_EXMEM = 1;
    localparam int STALL_MEM   = 2;
    localparam int STALL_WB    = 3;

    localparam logic [INST_W-1:0] EBREAK_INST = 32'h0010_0073;

    // a0 carries the exit code on a trap
    localparam logic [REG_ADDR_W-1:0] A0_IDX = 5'd10;

    typedef enum logic [2:0] {
        OP_NONE   = 3'd0,
        OP_ALU    = 3'd1,
        OP_LOAD   = 3'd2,
        OP_STORE  = 3'd3,
        OP_EBREAK = 3'd4
    } op_e;

    // Four-phase handshake toward data memory
    typedef enum logic [1:0] {
        MEM_IDLE    = 2'd0,
        MEM_REQ     = 2'd1,  // req high, waiting for ack
        MEM_RELEASE = 2'd2,  // req low, waiting for ack to drop
        MEM_DONE    = 2'd3
    } mem_state_e;

endpackage
